// ==== source/axi_arb_consts.svh ====
`ifndef AXI_ARB_CONSTS_SVH
`define AXI_ARB_CONSTS_SVH

// Managers sharing the one subordinate
`define AXI_ARB_NUM_M 2

`define AXI_ARB_ADDR_W 8
`define AXI_ARB_DATA_W 16

// Manager-side ID, before widening
`define AXI_ARB_ID_W 4

// Memory size in data words
`define AXI_ARB_MEM_DEPTH 128

`endif

// ==== source/axi_arb_pkg.sv ====
`include "axi_arb_consts.svh"

package axi_arb_pkg;

    typedef logic [`AXI_ARB_ADDR_W-1:0]        addr_t;
    typedef logic [`AXI_ARB_DATA_W-1:0]        data_t;
    typedef logic [`AXI_ARB_DATA_W/8-1:0]      strb_t;
    typedef logic [`AXI_ARB_ID_W-1:0]          id_t;
    typedef logic [$clog2(`AXI_ARB_NUM_M)-1:0] mgr_t;
    // Manager index on top of the manager's own ID
    typedef logic [$bits(mgr_t)+`AXI_ARB_ID_W-1:0] mid_t;
    typedef logic [7:0]                        len_t;
    typedef logic [1:0]                        resp_t;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP_WAIT} wr_arb_state_t;
    typedef enum logic [1:0] {MW_IDLE, MW_DATA, MW_RESP} mem_wr_state_t;
    typedef enum logic {MR_IDLE, MR_BURST} mem_rd_state_t;

    // First requester at or after start, wrapping around
    function automatic mgr_t rr_pick(input logic [`AXI_ARB_NUM_M-1:0] req, input mgr_t start);
        mgr_t pick;
        int   idx;
        pick = start;
        for (int i = `AXI_ARB_NUM_M - 1; i >= 0; i--) begin
            idx = (int'(start) + i) % `AXI_ARB_NUM_M;
            if (req[idx]) begin
                pick = mgr_t'(idx);
            end
        end
        return pick;
    endfunction

    function automatic mgr_t rr_next(input mgr_t cur);
        return mgr_t'((int'(cur) + 1) % `AXI_ARB_NUM_M);
    endfunction

endpackage

// ==== source/axi_arb_wr.sv ====
`timescale 1ns/1ps

`include "axi_arb_consts.svh"

module axi_arb_wr import axi_arb_pkg::*; (
    input  logic                              clk,
    input  logic                              i_rst_n,

    // Manager side
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_awvalid,
    input  id_t   [`AXI_ARB_NUM_M-1:0]        i_s_awid,
    input  addr_t [`AXI_ARB_NUM_M-1:0]        i_s_awaddr,
    input  len_t  [`AXI_ARB_NUM_M-1:0]        i_s_awlen,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_awready,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_wvalid,
    input  data_t [`AXI_ARB_NUM_M-1:0]        i_s_wdata,
    input  strb_t [`AXI_ARB_NUM_M-1:0]        i_s_wstrb,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_wlast,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_wready,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_bvalid,
    output id_t   [`AXI_ARB_NUM_M-1:0]        o_s_bid,
    output resp_t [`AXI_ARB_NUM_M-1:0]        o_s_bresp,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_bready,

    // Subordinate side
    output logic                              o_m_awvalid,
    output mid_t                              o_m_awid,
    output addr_t                             o_m_awaddr,
    output len_t                              o_m_awlen,
    input  logic                              i_m_awready,
    output logic                              o_m_wvalid,
    output data_t                             o_m_wdata,
    output strb_t                             o_m_wstrb,
    output logic                              o_m_wlast,
    input  logic                              i_m_wready,
    input  logic                              i_m_bvalid,
    input  mid_t                              i_m_bid,
    input  resp_t                             i_m_bresp,
    output logic                              o_m_bready
);

    wr_arb_state_t state;
    mgr_t          grant;
    mgr_t          rr_ptr;
    logic          aw_done;

    logic          aw_open;
    logic          w_open;
    logic          aw_fire;
    logic          wlast_fire;
    logic          b_fire;
    mgr_t          b_mgr;

    // AW stays open until the subordinate takes it, W for the whole burst
    assign aw_open    = (state == WR_DATA) && !aw_done;
    assign w_open     = (state == WR_DATA);

    assign aw_fire    = o_m_awvalid && i_m_awready;
    assign wlast_fire = o_m_wvalid && i_m_wready && o_m_wlast;
    assign b_fire     = i_m_bvalid && o_m_bready;

    // Owner of the response sits in the top bits of bid
    assign b_mgr = i_m_bid[$bits(mid_t)-1 -: $bits(mgr_t)];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= WR_IDLE;
            grant   <= '0;
            rr_ptr  <= '0;
            aw_done <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (|i_s_awvalid) begin
                        grant   <= rr_pick(i_s_awvalid, rr_ptr);
                        aw_done <= 1'b0;
                        state   <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (wlast_fire) begin
                        state <= WR_RESP_WAIT;
                    end
                end
                WR_RESP_WAIT: begin
                    // Hold the grant until B is gone
                    if (b_fire) begin
                        rr_ptr <= rr_next(grant);
                        state  <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        o_m_awvalid = aw_open && i_s_awvalid[grant];
        o_m_awid    = {grant, i_s_awid[grant]};
        o_m_awaddr  = i_s_awaddr[grant];
        o_m_awlen   = i_s_awlen[grant];

        o_m_wvalid  = w_open && i_s_wvalid[grant];
        o_m_wdata   = i_s_wdata[grant];
        o_m_wstrb   = i_s_wstrb[grant];
        o_m_wlast   = i_s_wlast[grant];

        o_m_bready  = i_s_bready[b_mgr];

        for (int m = 0; m < `AXI_ARB_NUM_M; m++) begin
            o_s_awready[m] = aw_open && (grant == mgr_t'(m)) && i_m_awready;
            o_s_wready[m]  = w_open && (grant == mgr_t'(m)) && i_m_wready;
            o_s_bvalid[m]  = i_m_bvalid && (b_mgr == mgr_t'(m));
            o_s_bid[m]     = i_m_bid[`AXI_ARB_ID_W-1:0];
            o_s_bresp[m]   = i_m_bresp;
        end
    end

endmodule

// ==== source/axi_arb_rd.sv ====
`timescale 1ns/1ps

`include "axi_arb_consts.svh"

module axi_arb_rd import axi_arb_pkg::*; (
    input  logic                              clk,
    input  logic                              i_rst_n,

    // Manager side
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_arvalid,
    input  id_t   [`AXI_ARB_NUM_M-1:0]        i_s_arid,
    input  addr_t [`AXI_ARB_NUM_M-1:0]        i_s_araddr,
    input  len_t  [`AXI_ARB_NUM_M-1:0]        i_s_arlen,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_arready,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_rvalid,
    output id_t   [`AXI_ARB_NUM_M-1:0]        o_s_rid,
    output data_t [`AXI_ARB_NUM_M-1:0]        o_s_rdata,
    output resp_t [`AXI_ARB_NUM_M-1:0]        o_s_rresp,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_rlast,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_rready,

    // Subordinate side
    output logic                              o_m_arvalid,
    output mid_t                              o_m_arid,
    output addr_t                             o_m_araddr,
    output len_t                              o_m_arlen,
    input  logic                              i_m_arready,
    input  logic                              i_m_rvalid,
    input  mid_t                              i_m_rid,
    input  data_t                             i_m_rdata,
    input  resp_t                             i_m_rresp,
    input  logic                              i_m_rlast,
    output logic                              o_m_rready
);

    mgr_t rr_ptr;
    mgr_t pick;
    mgr_t r_mgr;

    assign pick  = rr_pick(i_s_arvalid, rr_ptr);
    assign r_mgr = i_m_rid[$bits(mid_t)-1 -: $bits(mgr_t)];

    // Pointer moves past the winner on every accepted AR
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rr_ptr <= '0;
        end else if (o_m_arvalid && i_m_arready) begin
            rr_ptr <= rr_next(pick);
        end
    end

    always_comb begin
        o_m_arvalid = |i_s_arvalid;
        o_m_arid    = {pick, i_s_arid[pick]};
        o_m_araddr  = i_s_araddr[pick];
        o_m_arlen   = i_s_arlen[pick];

        // R goes back to whoever the ID names
        o_m_rready  = i_s_rready[r_mgr];

        for (int m = 0; m < `AXI_ARB_NUM_M; m++) begin
            o_s_arready[m] = i_m_arready && (pick == mgr_t'(m));
            o_s_rvalid[m]  = i_m_rvalid && (r_mgr == mgr_t'(m));
            o_s_rid[m]     = i_m_rid[`AXI_ARB_ID_W-1:0];
            o_s_rdata[m]   = i_m_rdata;
            o_s_rresp[m]   = i_m_rresp;
            o_s_rlast[m]   = i_m_rlast && i_m_rvalid && (r_mgr == mgr_t'(m));
        end
    end

endmodule

// ==== source/axi_burst_mem.sv ====
`timescale 1ns/1ps

`include "axi_arb_consts.svh"

module axi_burst_mem import axi_arb_pkg::*; (
    input  logic  clk,
    input  logic  i_rst_n,

    input  logic  i_awvalid,
    input  mid_t  i_awid,
    input  addr_t i_awaddr,
    input  len_t  i_awlen,
    output logic  o_awready,
    input  logic  i_wvalid,
    input  data_t i_wdata,
    input  strb_t i_wstrb,
    input  logic  i_wlast,
    output logic  o_wready,
    output logic  o_bvalid,
    output mid_t  o_bid,
    output resp_t o_bresp,
    input  logic  i_bready,

    input  logic  i_arvalid,
    input  mid_t  i_arid,
    input  addr_t i_araddr,
    input  len_t  i_arlen,
    output logic  o_arready,
    output logic  o_rvalid,
    output mid_t  o_rid,
    output data_t o_rdata,
    output resp_t o_rresp,
    output logic  o_rlast,
    input  logic  i_rready
);

    localparam int    IDX_W     = $clog2(`AXI_ARB_MEM_DEPTH);
    localparam int    BYTE_SH   = $clog2($bits(strb_t));
    localparam resp_t RESP_OKAY = 2'b00;

    data_t            mem [`AXI_ARB_MEM_DEPTH];

    mem_wr_state_t    wr_state;
    logic [IDX_W-1:0] wr_idx;
    len_t             wr_left;
    mid_t             wr_id;
    logic             w_fire;
    logic             w_end;

    mem_rd_state_t    rd_state;
    logic [IDX_W-1:0] rd_idx;
    len_t             rd_left;
    mid_t             rd_id;

    assign o_awready = (wr_state == MW_IDLE);
    assign o_wready  = (wr_state == MW_DATA);
    assign o_bvalid  = (wr_state == MW_RESP);
    assign o_bid     = wr_id;
    assign o_bresp   = RESP_OKAY;

    assign w_fire = i_wvalid && o_wready;
    // Ends on wlast, or when awlen runs out first
    assign w_end  = i_wlast || (wr_left == '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_state <= MW_IDLE;
            rd_state <= MR_IDLE;
        end else begin
            case (wr_state)
                MW_IDLE: if (i_awvalid) wr_state <= MW_DATA;
                MW_DATA: if (w_fire && w_end) wr_state <= MW_RESP;
                MW_RESP: if (i_bready) wr_state <= MW_IDLE;
                default: wr_state <= MW_IDLE;
            endcase
            case (rd_state)
                MR_IDLE:  if (i_arvalid) rd_state <= MR_BURST;
                MR_BURST: if (i_rready && o_rlast) rd_state <= MR_IDLE;
                default:  rd_state <= MR_IDLE;
            endcase
        end
    end

    // Word index is byte address over strobe width, wrapping at depth
    always_ff @(posedge clk) begin
        if (o_awready && i_awvalid) begin
            wr_idx  <= IDX_W'(i_awaddr >> BYTE_SH);
            wr_left <= i_awlen;
            wr_id   <= i_awid;
        end else if (w_fire) begin
            wr_idx  <= wr_idx + 1'b1;
            wr_left <= wr_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (i_wstrb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign o_arready = (rd_state == MR_IDLE);
    assign o_rvalid  = (rd_state == MR_BURST);
    assign o_rid     = rd_id;
    assign o_rdata   = mem[rd_idx];
    assign o_rresp   = RESP_OKAY;
    assign o_rlast   = o_rvalid && (rd_left == '0);

    always_ff @(posedge clk) begin
        if (o_arready && i_arvalid) begin
            rd_idx  <= IDX_W'(i_araddr >> BYTE_SH);
            rd_left <= i_arlen;
            rd_id   <= i_arid;
        end else if (o_rvalid && i_rready) begin
            rd_idx  <= rd_idx + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
    end

endmodule

// ==== source/axi_arb_top.sv ====
`timescale 1ns/1ps

`include "axi_arb_consts.svh"

module axi_arb_top import axi_arb_pkg::*; (
    input  logic                              clk,
    input  logic                              i_rst_n,

    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_awvalid,
    input  id_t   [`AXI_ARB_NUM_M-1:0]        i_s_awid,
    input  addr_t [`AXI_ARB_NUM_M-1:0]        i_s_awaddr,
    input  len_t  [`AXI_ARB_NUM_M-1:0]        i_s_awlen,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_awready,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_wvalid,
    input  data_t [`AXI_ARB_NUM_M-1:0]        i_s_wdata,
    input  strb_t [`AXI_ARB_NUM_M-1:0]        i_s_wstrb,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_wlast,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_wready,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_bvalid,
    output id_t   [`AXI_ARB_NUM_M-1:0]        o_s_bid,
    output resp_t [`AXI_ARB_NUM_M-1:0]        o_s_bresp,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_bready,

    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_arvalid,
    input  id_t   [`AXI_ARB_NUM_M-1:0]        i_s_arid,
    input  addr_t [`AXI_ARB_NUM_M-1:0]        i_s_araddr,
    input  len_t  [`AXI_ARB_NUM_M-1:0]        i_s_arlen,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_arready,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_rvalid,
    output id_t   [`AXI_ARB_NUM_M-1:0]        o_s_rid,
    output data_t [`AXI_ARB_NUM_M-1:0]        o_s_rdata,
    output resp_t [`AXI_ARB_NUM_M-1:0]        o_s_rresp,
    output logic  [`AXI_ARB_NUM_M-1:0]        o_s_rlast,
    input  logic  [`AXI_ARB_NUM_M-1:0]        i_s_rready
);

    // Arbiter to memory, IDs already widened
    logic  m_awvalid;
    mid_t  m_awid;
    addr_t m_awaddr;
    len_t  m_awlen;
    logic  m_awready;
    logic  m_wvalid;
    data_t m_wdata;
    strb_t m_wstrb;
    logic  m_wlast;
    logic  m_wready;
    logic  m_bvalid;
    mid_t  m_bid;
    resp_t m_bresp;
    logic  m_bready;

    logic  m_arvalid;
    mid_t  m_arid;
    addr_t m_araddr;
    len_t  m_arlen;
    logic  m_arready;
    logic  m_rvalid;
    mid_t  m_rid;
    data_t m_rdata;
    resp_t m_rresp;
    logic  m_rlast;
    logic  m_rready;

    axi_arb_wr u_wr (
        .*,
        .o_m_awvalid (m_awvalid),
        .o_m_awid    (m_awid),
        .o_m_awaddr  (m_awaddr),
        .o_m_awlen   (m_awlen),
        .i_m_awready (m_awready),
        .o_m_wvalid  (m_wvalid),
        .o_m_wdata   (m_wdata),
        .o_m_wstrb   (m_wstrb),
        .o_m_wlast   (m_wlast),
        .i_m_wready  (m_wready),
        .i_m_bvalid  (m_bvalid),
        .i_m_bid     (m_bid),
        .i_m_bresp   (m_bresp),
        .o_m_bready  (m_bready)
    );

    axi_arb_rd u_rd (
        .*,
        .o_m_arvalid (m_arvalid),
        .o_m_arid    (m_arid),
        .o_m_araddr  (m_araddr),
        .o_m_arlen   (m_arlen),
        .i_m_arready (m_arready),
        .i_m_rvalid  (m_rvalid),
        .i_m_rid     (m_rid),
        .i_m_rdata   (m_rdata),
        .i_m_rresp   (m_rresp),
        .i_m_rlast   (m_rlast),
        .o_m_rready  (m_rready)
    );

    axi_burst_mem u_mem (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (m_awvalid),
        .i_awid    (m_awid),
        .i_awaddr  (m_awaddr),
        .i_awlen   (m_awlen),
        .o_awready (m_awready),
        .i_wvalid  (m_wvalid),
        .i_wdata   (m_wdata),
        .i_wstrb   (m_wstrb),
        .i_wlast   (m_wlast),
        .o_wready  (m_wready),
        .o_bvalid  (m_bvalid),
        .o_bid     (m_bid),
        .o_bresp   (m_bresp),
        .i_bready  (m_bready),
        .i_arvalid (m_arvalid),
        .i_arid    (m_arid),
        .i_araddr  (m_araddr),
        .i_arlen   (m_arlen),
        .o_arready (m_arready),
        .o_rvalid  (m_rvalid),
        .o_rid     (m_rid),
        .o_rdata   (m_rdata),
        .o_rresp   (m_rresp),
        .o_rlast   (m_rlast),
        .i_rready  (m_rready)
    );

endmodule

// ==== sim/axi_arb_properties.sv ====
`timescale 1ns/1ps

`include "axi_arb_consts.svh"

module axi_arb_properties import axi_arb_pkg::*; (
    input logic                        clk,
    input logic                        i_rst_n,
    input logic  [`AXI_ARB_NUM_M-1:0]  i_s_awvalid,
    input id_t   [`AXI_ARB_NUM_M-1:0]  i_s_awid,
    input addr_t [`AXI_ARB_NUM_M-1:0]  i_s_awaddr,
    input len_t  [`AXI_ARB_NUM_M-1:0]  i_s_awlen,
    input logic  [`AXI_ARB_NUM_M-1:0]  o_s_awready,
    input logic  [`AXI_ARB_NUM_M-1:0]  o_s_wready,
    input logic  [`AXI_ARB_NUM_M-1:0]  o_s_bvalid,
    input id_t   [`AXI_ARB_NUM_M-1:0]  o_s_bid,
    input logic  [`AXI_ARB_NUM_M-1:0]  i_s_bready,
    input logic  [`AXI_ARB_NUM_M-1:0]  o_s_rvalid,
    input id_t   [`AXI_ARB_NUM_M-1:0]  o_s_rid,
    input data_t [`AXI_ARB_NUM_M-1:0]  o_s_rdata,
    input logic  [`AXI_ARB_NUM_M-1:0]  o_s_rlast,
    input logic  [`AXI_ARB_NUM_M-1:0]  i_s_rready
);

    // W goes to the granted manager only
    assert property (@(posedge clk) disable iff (!i_rst_n) $onehot0(o_s_wready))
        else $error("wready seen by more than one manager");

    genvar m;
    generate
        for (m = 0; m < `AXI_ARB_NUM_M; m++) begin : g_mgr
            assert property (@(posedge clk) disable iff (!i_rst_n)
                i_s_awvalid[m] && !o_s_awready[m] |=> i_s_awvalid[m]
                    && $stable(i_s_awaddr[m]) && $stable(i_s_awlen[m]) && $stable(i_s_awid[m]))
                else $error("AW of manager %0d changed under back-pressure", m);

            assert property (@(posedge clk) disable iff (!i_rst_n)
                o_s_bvalid[m] && !i_s_bready[m] |=> o_s_bvalid[m] && $stable(o_s_bid[m]))
                else $error("B of manager %0d changed under back-pressure", m);

            assert property (@(posedge clk) disable iff (!i_rst_n)
                o_s_rvalid[m] && !i_s_rready[m] |=> o_s_rvalid[m]
                    && $stable(o_s_rdata[m]) && $stable(o_s_rid[m]) && $stable(o_s_rlast[m]))
                else $error("R of manager %0d changed under back-pressure", m);

            assert property (@(posedge clk) disable iff (!i_rst_n)
                o_s_rlast[m] |-> o_s_rvalid[m])
                else $error("rlast without rvalid on manager %0d", m);
        end
    endgenerate

endmodule

bind axi_arb_top axi_arb_properties u_props (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_s_awvalid (i_s_awvalid),
    .i_s_awid    (i_s_awid),
    .i_s_awaddr  (i_s_awaddr),
    .i_s_awlen   (i_s_awlen),
    .o_s_awready (o_s_awready),
    .o_s_wready  (o_s_wready),
    .o_s_bvalid  (o_s_bvalid),
    .o_s_bid     (o_s_bid),
    .i_s_bready  (i_s_bready),
    .o_s_rvalid  (o_s_rvalid),
    .o_s_rid     (o_s_rid),
    .o_s_rdata   (o_s_rdata),
    .o_s_rlast   (o_s_rlast),
    .i_s_rready  (i_s_rready)
);

// ==== sim/axi_arb_tb.sv ====
`timescale 1ns/1ps

`include "axi_arb_consts.svh"

module axi_arb_tb import axi_arb_pkg::*; ();

    localparam int NM          = `AXI_ARB_NUM_M;
    localparam int MAX_BEATS   = 8;
    // 12 directed bursts, 80 random, 8 for fairness
    localparam int NUM_BURSTS  = 100;
    localparam int CYCLE_LIMIT = 2 * NUM_BURSTS * MAX_BEATS + 2000;

    logic            clk = 1'b0;
    logic            i_rst_n;
    logic  [NM-1:0]  i_s_awvalid;
    id_t   [NM-1:0]  i_s_awid;
    addr_t [NM-1:0]  i_s_awaddr;
    len_t  [NM-1:0]  i_s_awlen;
    logic  [NM-1:0]  o_s_awready;
    logic  [NM-1:0]  i_s_wvalid;
    data_t [NM-1:0]  i_s_wdata;
    strb_t [NM-1:0]  i_s_wstrb;
    logic  [NM-1:0]  i_s_wlast;
    logic  [NM-1:0]  o_s_wready;
    logic  [NM-1:0]  o_s_bvalid;
    id_t   [NM-1:0]  o_s_bid;
    resp_t [NM-1:0]  o_s_bresp;
    logic  [NM-1:0]  i_s_bready;
    logic  [NM-1:0]  i_s_arvalid;
    id_t   [NM-1:0]  i_s_arid;
    addr_t [NM-1:0]  i_s_araddr;
    len_t  [NM-1:0]  i_s_arlen;
    logic  [NM-1:0]  o_s_arready;
    logic  [NM-1:0]  o_s_rvalid;
    id_t   [NM-1:0]  o_s_rid;
    data_t [NM-1:0]  o_s_rdata;
    resp_t [NM-1:0]  o_s_rresp;
    logic  [NM-1:0]  o_s_rlast;
    logic  [NM-1:0]  i_s_rready;

    logic [31:0] lfsr = 32'hea77156e;
    logic [7:0]  ref_mem [256];
    int          errors;
    int          test_num;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;
    int          cycles;
    int          b_count [NM];
    int          b_order [$];

    // Open read per manager, consumed by the R monitor
    bit          rd_active [NM];
    addr_t       rd_addr [NM];
    len_t        rd_len [NM];
    id_t         rd_id [NM];
    int          rd_beat [NM];

    axi_arb_top UUT (.*);

    always #4 clk = ~clk;

    function automatic logic rand_bit();
        lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hb4bcd35c : 32'h0);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // Expected word at a byte address, low byte at the even address
    function automatic data_t ref_word(input addr_t a);
        int base;
        base = int'(a) & 32'hfe;
        return {ref_mem[base + 1], ref_mem[base]};
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic start_test();
        test_num++;
        test_errs = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errs) begin
            tests_ok++;
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: %0d errors", test_num, name, errors - test_errs);
        end
    endtask

    // Starts on a falling edge and returns on one, so back-to-back calls keep AW pending
    task automatic write_burst(input int m, input addr_t addr, input len_t len, input id_t id,
                               input bit part, input bit stall);
        data_t wd [256];
        strb_t ws [256];
        int    wa;
        for (int b = 0; b <= int'(len); b++) begin
            wd[b] = data_t'(rand_bits(16));
            // Partial mode walks through all four strobe patterns
            ws[b] = part ? strb_t'(b) : '1;
        end
        i_s_awvalid[m] = 1'b1;
        i_s_awid[m]    = id;
        i_s_awaddr[m]  = addr;
        i_s_awlen[m]   = len;
        do @(posedge clk); while (!o_s_awready[m]);
        @(negedge clk);
        i_s_awvalid[m] = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            while (stall && rand_bit()) @(negedge clk);
            i_s_wvalid[m] = 1'b1;
            i_s_wdata[m]  = wd[b];
            i_s_wstrb[m]  = ws[b];
            i_s_wlast[m]  = (b == int'(len));
            do @(posedge clk); while (!o_s_wready[m]);
            @(negedge clk);
            i_s_wvalid[m] = 1'b0;
            i_s_wlast[m]  = 1'b0;
        end
        forever begin
            i_s_bready[m] = stall ? rand_bit() : 1'b1;
            @(posedge clk);
            if (o_s_bvalid[m] && i_s_bready[m]) break;
            @(negedge clk);
        end
        check_eq($sformatf("m%0d bid", m), 32'(o_s_bid[m]), 32'(id));
        check_eq($sformatf("m%0d bresp", m), 32'(o_s_bresp[m]), 32'h0);
        // Model takes the burst once its B is seen
        for (int b = 0; b <= int'(len); b++) begin
            wa = ((int'(addr) & 32'hfe) + 2 * b) % 256;
            for (int k = 0; k < 2; k++) begin
                if (ws[b][k]) begin
                    ref_mem[wa + k] = wd[b][k*8 +: 8];
                end
            end
        end
        @(negedge clk);
        i_s_bready[m] = 1'b0;
    endtask

    task automatic read_burst(input int m, input addr_t addr, input len_t len, input id_t id,
                              input bit stall);
        bit ar_done;
        @(negedge clk);
        rd_addr[m]     = addr;
        rd_len[m]      = len;
        rd_id[m]       = id;
        rd_beat[m]     = 0;
        rd_active[m]   = 1'b1;
        ar_done        = 1'b0;
        i_s_arvalid[m] = 1'b1;
        i_s_arid[m]    = id;
        i_s_araddr[m]  = addr;
        i_s_arlen[m]   = len;
        forever begin
            i_s_rready[m] = stall ? rand_bit() : 1'b1;
            @(posedge clk);
            if (i_s_arvalid[m] && o_s_arready[m]) ar_done = 1'b1;
            @(negedge clk);
            if (ar_done) i_s_arvalid[m] = 1'b0;
            if (ar_done && !rd_active[m]) break;
        end
        i_s_rready[m] = 1'b0;
    endtask

    task automatic random_traffic(input int m);
        int    off;
        len_t  len;
        id_t   id;
        addr_t addr;
        for (int i = 0; i < 20; i++) begin
            off  = int'(rand_bits(6)) % 56;
            len  = len_t'(rand_bits(3));
            id   = id_t'(rand_bits(4));
            // Each manager keeps to its own half of the memory
            addr = addr_t'(m * 128 + 2 * off);
            write_burst(m, addr, len, id, 1'b0, 1'b1);
            read_burst(m, addr, len, id, 1'b1);
        end
    endtask

    // R compare and B bookkeeping
    always @(posedge clk) begin
        for (int m = 0; m < NM; m++) begin
            if (o_s_bvalid[m] && i_s_bready[m]) begin
                b_count[m]++;
                b_order.push_back(m);
            end
            if (o_s_rvalid[m] && i_s_rready[m]) begin
                if (!rd_active[m]) begin
                    check_eq($sformatf("m%0d R beat with no read open", m), 32'h0, 32'h1);
                end else begin
                    check_eq($sformatf("m%0d rdata beat %0d", m, rd_beat[m]),
                             32'(o_s_rdata[m]), 32'(ref_word(rd_addr[m] + addr_t'(2 * rd_beat[m]))));
                    check_eq($sformatf("m%0d rid", m), 32'(o_s_rid[m]), 32'(rd_id[m]));
                    check_eq($sformatf("m%0d rresp", m), 32'(o_s_rresp[m]), 32'h0);
                    check_eq($sformatf("m%0d rlast beat %0d", m, rd_beat[m]),
                             32'(o_s_rlast[m]), 32'(rd_beat[m] == int'(rd_len[m])));
                    if (rd_beat[m] == int'(rd_len[m])) begin
                        rd_active[m] = 1'b0;
                    end else begin
                        rd_beat[m]++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        i_rst_n     = 1'b0;
        i_s_awvalid = '0;
        i_s_awid    = '0;
        i_s_awaddr  = '0;
        i_s_awlen   = '0;
        i_s_wvalid  = '0;
        i_s_wdata   = '0;
        i_s_wstrb   = '0;
        i_s_wlast   = '0;
        i_s_bready  = '0;
        i_s_arvalid = '0;
        i_s_arid    = '0;
        i_s_araddr  = '0;
        i_s_arlen   = '0;
        i_s_rready  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        start_test();
        write_burst(0, 8'h00, 8'd7, 4'h3, 1'b0, 1'b0);
        read_burst(0, 8'h00, 8'd7, 4'h3, 1'b0);
        end_test("single write and read-back");

        start_test();
        b_count = '{default: 0};
        fork
            write_burst(0, 8'h20, 8'd5, 4'h1, 1'b0, 1'b0);
            write_burst(1, 8'ha0, 8'd6, 4'h9, 1'b0, 1'b0);
        join
        check_eq("m0 B count", 32'(b_count[0]), 32'd1);
        check_eq("m1 B count", 32'(b_count[1]), 32'd1);
        read_burst(0, 8'h20, 8'd5, 4'h1, 1'b0);
        read_burst(1, 8'ha0, 8'd6, 4'h9, 1'b0);
        end_test("simultaneous writes");

        start_test();
        write_burst(1, 8'h90, 8'd3, 4'h5, 1'b0, 1'b0);
        write_burst(1, 8'h90, 8'd3, 4'h6, 1'b1, 1'b0);
        write_burst(1, 8'h92, 8'd1, 4'h7, 1'b1, 1'b0);
        read_burst(1, 8'h90, 8'd3, 4'h5, 1'b0);
        end_test("partial strobes");

        start_test();
        fork
            read_burst(0, 8'h20, 8'd5, 4'h2, 1'b0);
            read_burst(1, 8'ha0, 8'd6, 4'hb, 1'b0);
        join
        end_test("concurrent reads");

        start_test();
        fork
            random_traffic(0);
            random_traffic(1);
        join
        end_test("random bursts with stalls");

        // Both keep AW pending, so grants must alternate
        start_test();
        b_order.delete();
        fork
            begin
                for (int i = 0; i < 4; i++) write_burst(0, 8'h40, 8'd2, 4'h4, 1'b0, 1'b0);
            end
            begin
                for (int i = 0; i < 4; i++) write_burst(1, 8'hc0, 8'd2, 4'hc, 1'b0, 1'b0);
            end
        join
        check_eq("B completions in fairness test", 32'(b_order.size()), 32'd8);
        for (int i = 1; i < b_order.size(); i++) begin
            check_eq($sformatf("B %0d alternates", i), 32'(b_order[i] != b_order[i-1]), 32'h1);
        end
        end_test("round-robin fairness");

        $display("Tests passed: %0d, failed: %0d, failed checks: %0d",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/axi_arb_pkg.sv
source/axi_arb_wr.sv
source/axi_arb_rd.sv
source/axi_burst_mem.sv
source/axi_arb_top.sv
sim/axi_arb_properties.sv
sim/axi_arb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the AXI arbiter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module axi_arb_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vaxi_arb_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
